// File: Makefile
TOP := qeci_link_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the loopback simulation with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f qeci_link.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: qeci_link.f
src/qeci_pkg.sv
src/qeci_ctrl_if.sv
src/qeci_crc8.sv
src/qeci_tx_framer.sv
src/qeci_rx_deframer.sv
src/qeci_link_ctrl.sv
src/qeci_link.sv
tb/qeci_link_sva.sv
tb/qeci_link_tb.sv

// File: src/qeci_crc8.sv
// Combinational CRC-8 over one payload word
// Zero seed, MSB first, no final XOR

`timescale 1ns/10ps

module qeci_crc8 (
   input  logic [qeci_pkg::WORD_W-1:0] payload,
   output logic [qeci_pkg::CRC_W-1:0]  crc
);

   logic [qeci_pkg::CRC_W-1:0] acc;
   logic                       fb;

   // Bit-serial LFSR, unrolled over the word
   always_comb begin
      acc = '0;
      fb  = 1'b0;
      for (int i = qeci_pkg::WORD_W - 1; i >= 0; i--) begin
         fb  = acc[qeci_pkg::CRC_W-1] ^ payload[i];
         acc = {acc[qeci_pkg::CRC_W-2:0], 1'b0};
         if (fb) begin
            acc = acc ^ qeci_pkg::CRC_POLY;
         end
      end
   end

   assign crc = acc;

endmodule

// File: src/qeci_ctrl_if.sv
// Control and event lines between the link controller and the datapath

`timescale 1ns/10ps

interface qeci_ctrl_if;

   logic       tx_train;
   logic       link_up;
   logic       align_seen;
   logic       bad_frame;
   logic [3:0] bad_code;

   modport ctrl (
      output tx_train,
      output link_up,
      input  align_seen,
      input  bad_frame,
      input  bad_code
   );

   modport framer (
      input tx_train,
      input link_up
   );

   // bad_frame is also read back by the deframer itself
   modport deframer (
      input  link_up,
      output align_seen,
      output bad_frame,
      output bad_code
   );

endinterface

// File: src/qeci_link.sv
// QECI link layer top level
// Controller, transmit framer and receive deframer joined through the control interface

`timescale 1ns/10ps

module qeci_link (
   input  logic                        FCLK,
   input  logic                        ARSTn,
   input  logic [qeci_pkg::WORD_W-1:0] tx_data,
   input  logic                        tx_valid,
   output logic                        tx_ready,
   output logic                        link_tx_valid,
   output qeci_pkg::qeci_frame_u       link_tx_frame,
   input  logic                        link_rx_valid,
   input  qeci_pkg::qeci_frame_u       link_rx_frame,
   output logic [qeci_pkg::WORD_W-1:0] rx_data,
   output logic                        rx_valid,
   output logic [3:0]                  status,
   output logic [3:0]                  ecode
);

   qeci_ctrl_if i_ctrl_if ();

   qeci_link_ctrl i_link_ctrl (
      .FCLK  (FCLK),
      .ARSTn (ARSTn),
      .ctrl  (i_ctrl_if.ctrl),
      .status(status),
      .ecode (ecode)
   );

   qeci_tx_framer i_tx_framer (
      .FCLK         (FCLK),
      .ARSTn        (ARSTn),
      .ctrl         (i_ctrl_if.framer),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .tx_ready     (tx_ready),
      .link_tx_valid(link_tx_valid),
      .link_tx_frame(link_tx_frame)
   );

   qeci_rx_deframer i_rx_deframer (
      .FCLK         (FCLK),
      .ARSTn        (ARSTn),
      .ctrl         (i_ctrl_if.deframer),
      .link_rx_valid(link_rx_valid),
      .link_rx_frame(link_rx_frame),
      .rx_data      (rx_data),
      .rx_valid     (rx_valid)
   );

endmodule

// File: src/qeci_link_ctrl.sv
// Link controller
// Trains the link on consecutive align frames and latches the first fault

`timescale 1ns/10ps

module qeci_link_ctrl (
   input  logic       FCLK,
   input  logic       ARSTn,
   qeci_ctrl_if.ctrl  ctrl,
   output logic [3:0] status,
   output logic [3:0] ecode
);

   localparam int CNT_W = $clog2(qeci_pkg::ALIGN_COUNT + 1);

   logic [CNT_W-1:0] align_cnt;
   logic [CNT_W-1:0] align_cnt_nxt;
   logic [3:0]       status_nxt;
   logic [3:0]       ecode_nxt;

   // Any cycle without an align pulse breaks the run
   assign align_cnt_nxt = ctrl.align_seen ? align_cnt + 1'b1 : '0;

   always_comb begin
      status_nxt = status;
      ecode_nxt  = ecode;
      if (status != qeci_pkg::ST_FAULT && ctrl.bad_frame) begin
         status_nxt = qeci_pkg::ST_FAULT;
         ecode_nxt  = ctrl.bad_code;
      end else begin
         case (status)
            qeci_pkg::ST_RESET: begin
               status_nxt = qeci_pkg::ST_ALIGN;
            end
            qeci_pkg::ST_ALIGN: begin
               if (ctrl.align_seen && align_cnt == CNT_W'(qeci_pkg::ALIGN_COUNT - 1)) begin
                  status_nxt = qeci_pkg::ST_LINKUP;
               end
            end
            qeci_pkg::ST_LINKUP: begin
               status_nxt = qeci_pkg::ST_LINKUP;
            end
            // Fault is held until reset
            default: begin
               status_nxt = qeci_pkg::ST_FAULT;
            end
         endcase
      end
   end

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         status    <= qeci_pkg::ST_RESET;
         ecode     <= qeci_pkg::EC_NONE;
         align_cnt <= '0;
      end else begin
         status    <= status_nxt;
         ecode     <= ecode_nxt;
         align_cnt <= (status == qeci_pkg::ST_ALIGN) ? align_cnt_nxt : '0;
      end
   end

   // Datapath controls decoded from the state
   assign ctrl.tx_train = (status == qeci_pkg::ST_ALIGN);
   assign ctrl.link_up  = (status == qeci_pkg::ST_LINKUP);

endmodule

// File: src/qeci_pkg.sv
// Shared definitions for the QECI link layer
// Widths, CRC and control codes, status and error codes, frame layout

package qeci_pkg;

   // Widths
   localparam int WORD_W  = 64;
   localparam int CRC_W   = 8;
   localparam int FRAME_W = 1 + CRC_W + WORD_W;

   // CRC-8, zero seed, MSB first
   localparam logic [CRC_W-1:0] CRC_POLY = 8'h07;

   // Control frame codes
   localparam logic [7:0]        CODE_ALIGN    = 8'hBC;
   localparam logic [7:0]        CODE_IDLE     = 8'h1C;
   localparam logic [WORD_W-1:0] ALIGN_PATTERN = 64'hA5A5_5A5A_C3C3_3C3C;
   localparam int                ALIGN_COUNT   = 4;

   // STATUS codes
   localparam logic [3:0] ST_RESET  = 4'b0000;
   localparam logic [3:0] ST_ALIGN  = 4'b0001;
   localparam logic [3:0] ST_LINKUP = 4'b0100;
   localparam logic [3:0] ST_FAULT  = 4'b1000;

   // ECODE codes
   localparam logic [3:0] EC_NONE       = 4'b0000;
   localparam logic [3:0] EC_CRC        = 4'b0001;
   localparam logic [3:0] EC_UNEXPECTED = 4'b0010;
   localparam logic [3:0] EC_BAD_CTRL   = 4'b0011;

   typedef struct packed {
      logic              kind;
      logic [CRC_W-1:0]  crc;
      logic [WORD_W-1:0] payload;
   } data_frame_t;

   typedef struct packed {
      logic              kind;
      logic [7:0]        code;
      logic [WORD_W-1:0] info;
   } ctrl_frame_t;

   // One link frame, read by its kind bit
   typedef union packed {
      data_frame_t data;
      ctrl_frame_t ctrl;
   } qeci_frame_u;

endpackage

// File: src/qeci_rx_deframer.sv
// Receive deframer
// Checks each link frame, forwards good data words and reports align and error events

`timescale 1ns/10ps

module qeci_rx_deframer (
   input  logic                        FCLK,
   input  logic                        ARSTn,
   qeci_ctrl_if.deframer               ctrl,
   input  logic                        link_rx_valid,
   input  qeci_pkg::qeci_frame_u       link_rx_frame,
   output logic [qeci_pkg::WORD_W-1:0] rx_data,
   output logic                        rx_valid
);

   logic [qeci_pkg::CRC_W-1:0] crc_rx;
   logic                       valid_nxt;
   logic                       align_nxt;
   logic                       bad_nxt;
   logic [3:0]                 code_nxt;

   qeci_crc8 i_crc8 (
      .payload(link_rx_frame.data.payload),
      .crc    (crc_rx)
   );

   always_comb begin
      valid_nxt = 1'b0;
      align_nxt = 1'b0;
      bad_nxt   = 1'b0;
      code_nxt  = qeci_pkg::EC_NONE;
      if (link_rx_valid) begin
         if (!link_rx_frame.data.kind) begin
            if (!ctrl.link_up) begin
               bad_nxt  = 1'b1;
               code_nxt = qeci_pkg::EC_UNEXPECTED;
            end else if (crc_rx != link_rx_frame.data.crc) begin
               bad_nxt  = 1'b1;
               code_nxt = qeci_pkg::EC_CRC;
            end else if (!ctrl.bad_frame) begin
               // The controller faults on this edge, so drop the word behind a bad one
               valid_nxt = 1'b1;
            end
         end else if (link_rx_frame.ctrl.code == qeci_pkg::CODE_ALIGN &&
                      link_rx_frame.ctrl.info == qeci_pkg::ALIGN_PATTERN) begin
            align_nxt = 1'b1;
         end else if (link_rx_frame.ctrl.code != qeci_pkg::CODE_IDLE) begin
            // Unknown code, or an align frame with a damaged pattern
            bad_nxt  = 1'b1;
            code_nxt = qeci_pkg::EC_BAD_CTRL;
         end
      end
   end

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rx_valid        <= 1'b0;
         ctrl.align_seen <= 1'b0;
         ctrl.bad_frame  <= 1'b0;
      end else begin
         rx_valid        <= valid_nxt;
         ctrl.align_seen <= align_nxt;
         ctrl.bad_frame  <= bad_nxt;
      end
   end

   always_ff @(posedge FCLK) begin
      if (valid_nxt) begin
         rx_data <= link_rx_frame.data.payload;
      end
      ctrl.bad_code <= code_nxt;
   end

endmodule

// File: src/qeci_tx_framer.sv
// Transmit framer
// Sends stream words as CRC-protected data frames, and align or idle frames between them

`timescale 1ns/10ps

module qeci_tx_framer (
   input  logic                        FCLK,
   input  logic                        ARSTn,
   qeci_ctrl_if.framer                 ctrl,
   input  logic [qeci_pkg::WORD_W-1:0] tx_data,
   input  logic                        tx_valid,
   output logic                        tx_ready,
   output logic                        link_tx_valid,
   output qeci_pkg::qeci_frame_u       link_tx_frame
);

   logic [qeci_pkg::CRC_W-1:0] crc_tx;
   qeci_pkg::qeci_frame_u      frame_nxt;

   qeci_crc8 i_crc8 (
      .payload(tx_data),
      .crc    (crc_tx)
   );

   // Words are only taken while the link is up
   assign tx_ready = ctrl.link_up;

   always_comb begin
      frame_nxt = '0;
      if (tx_valid && tx_ready) begin
         frame_nxt.data.kind    = 1'b0;
         frame_nxt.data.crc     = crc_tx;
         frame_nxt.data.payload = tx_data;
      end else if (ctrl.tx_train) begin
         frame_nxt.ctrl.kind = 1'b1;
         frame_nxt.ctrl.code = qeci_pkg::CODE_ALIGN;
         frame_nxt.ctrl.info = qeci_pkg::ALIGN_PATTERN;
      end else begin
         // Idle carries no info
         frame_nxt.ctrl.kind = 1'b1;
         frame_nxt.ctrl.code = qeci_pkg::CODE_IDLE;
         frame_nxt.ctrl.info = '0;
      end
   end

   // A frame goes out every cycle once out of reset
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         link_tx_valid <= 1'b0;
      end else begin
         link_tx_valid <= 1'b1;
      end
   end

   always_ff @(posedge FCLK) begin
      link_tx_frame <= frame_nxt;
   end

endmodule

// File: tb/qeci_link_sva.sv
// Protocol assertions for the QECI link layer top level

`timescale 1ns/10ps

module qeci_link_sva (
   input logic                        FCLK,
   input logic                        ARSTn,
   input logic [qeci_pkg::WORD_W-1:0] tx_data,
   input logic                        tx_valid,
   input logic                        tx_ready,
   input qeci_pkg::qeci_frame_u       link_tx_frame,
   input logic                        rx_valid,
   input logic                        link_tx_valid,
   input logic [3:0]                  status
);

   // Words are taken only on a trained link and go out as data frames a cycle later
   a_ready_linkup: assert property (@(posedge FCLK) disable iff (!ARSTn)
      tx_valid && tx_ready |=> $past(status) == qeci_pkg::ST_LINKUP &&
      !link_tx_frame.data.kind && link_tx_frame.data.payload == $past(tx_data))
      else $error("accepted word did not become a data frame on a trained link");

   a_rx_linkup: assert property (@(posedge FCLK) disable iff (!ARSTn)
      rx_valid |-> status == qeci_pkg::ST_LINKUP)
      else $error("rx_valid high while the link is not up");

   // Fault is only left through reset
   a_fault_holds: assert property (@(posedge FCLK) disable iff (!ARSTn)
      status == qeci_pkg::ST_FAULT |=> status == qeci_pkg::ST_FAULT)
      else $error("status left the fault state without reset");

   a_link_valid_holds: assert property (@(posedge FCLK) disable iff (!ARSTn)
      link_tx_valid |=> link_tx_valid)
      else $error("link_tx_valid dropped outside reset");

endmodule

bind qeci_link qeci_link_sva i_sva (
   .FCLK         (FCLK),
   .ARSTn        (ARSTn),
   .tx_data      (tx_data),
   .tx_valid     (tx_valid),
   .tx_ready     (tx_ready),
   .link_tx_frame(link_tx_frame),
   .rx_valid     (rx_valid),
   .link_tx_valid(link_tx_valid),
   .status       (status)
);

// File: tb/qeci_link_tb.sv
// Loopback testbench for the QECI link layer
// Trains the link, streams table words with gaps, injects a CRC error, then retrains

`timescale 1ns/10ps

module qeci_link_tb;

   localparam int N_ROWS         = 8;
   localparam int TIMEOUT_CYCLES = 4 * N_ROWS + 64;
   // Two adjacent payload bits, a burst that CRC-8 always catches
   localparam logic [qeci_pkg::FRAME_W-1:0] BURST_FLIP = 73'h300_0000_0000;

   typedef struct packed {
      logic [qeci_pkg::WORD_W-1:0]  payload;
      logic                         valid;
      logic [qeci_pkg::FRAME_W-1:0] flip;
      logic                         expect_rx;
   } row_t;

   logic                         FCLK;
   logic                         ARSTn;
   logic [qeci_pkg::WORD_W-1:0]  tx_data;
   logic                         tx_valid;
   logic                         tx_ready;
   logic                         link_tx_valid;
   qeci_pkg::qeci_frame_u        link_tx_frame;
   qeci_pkg::qeci_frame_u        link_rx_frame;
   logic [qeci_pkg::WORD_W-1:0]  rx_data;
   logic                         rx_valid;
   logic [3:0]                   status;
   logic [3:0]                   ecode;
   logic [qeci_pkg::FRAME_W-1:0] flip;
   row_t                         rows [N_ROWS];
   integer                       seed = 92856;
   int                           cycle_cnt = 0;

   // Loopback with bit error injection
   assign link_rx_frame = link_tx_frame ^ flip;

   qeci_link i_dut (
      .FCLK         (FCLK),
      .ARSTn        (ARSTn),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .tx_ready     (tx_ready),
      .link_tx_valid(link_tx_valid),
      .link_tx_frame(link_tx_frame),
      .link_rx_valid(link_tx_valid),
      .link_rx_frame(link_rx_frame),
      .rx_data      (rx_data),
      .rx_valid     (rx_valid),
      .status       (status),
      .ecode        (ecode)
   );

   always #4 FCLK = ~FCLK;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   always @(posedge FCLK) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         report_failure($sformatf("Timeout: the run did not end within %0d cycles", cycle_cnt));
      end
   end

   task automatic check_word(input string what, input logic [qeci_pkg::WORD_W-1:0] got,
                             input logic [qeci_pkg::WORD_W-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_status(input logic [3:0] got_st, input logic [3:0] got_ec,
                               input logic [3:0] exp_st, input logic [3:0] exp_ec);
      if (got_st !== exp_st || got_ec !== exp_ec) begin
         report_failure($sformatf("[FAIL] %0t ns: status/ecode are %b/%b, expected %b/%b",
                                  $time, got_st, got_ec, exp_st, exp_ec));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_frame(input int row, input qeci_pkg::qeci_frame_u got,
                              input qeci_pkg::qeci_frame_u exp);
      if (got !== exp) begin
         report_failure($sformatf("[FAIL] %0t ns: link frame of row %0d is %h, expected %h",
                                  $time, row, got, exp));
      end
   endtask

   // Reference CRC-8, zero seed, fed a byte at a time from the top
   function automatic logic [7:0] crc8_ref(input logic [qeci_pkg::WORD_W-1:0] word);
      logic [7:0] c;
      c = 8'h00;
      for (int b = qeci_pkg::WORD_W / 8 - 1; b >= 0; b--) begin
         c = c ^ word[8*b +: 8];
         for (int k = 0; k < 8; k++) begin
            c = c[7] ? ({c[6:0], 1'b0} ^ qeci_pkg::CRC_POLY) : {c[6:0], 1'b0};
         end
      end
      return c;
   endfunction

   task automatic step();
      @(posedge FCLK);
      #1;
   endtask

   function automatic logic [qeci_pkg::WORD_W-1:0] rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // Payload, valid, flip mask, expected on rx
   task automatic fill_table();
      rows[0] = '{rand_word(), 1'b1, '0, 1'b1};
      rows[1] = '{rand_word(), 1'b1, '0, 1'b1};
      rows[2] = '{rand_word(), 1'b0, '0, 1'b0};
      rows[3] = '{rand_word(), 1'b1, '0, 1'b1};
      rows[4] = '{rand_word(), 1'b0, '0, 1'b0};
      rows[5] = '{rand_word(), 1'b0, '0, 1'b0};
      // Row 6 is corrupted on the link and row 7 trails it into the fault
      rows[6] = '{rand_word(), 1'b1, BURST_FLIP, 1'b0};
      rows[7] = '{rand_word(), 1'b1, '0, 1'b0};
   endtask

   task automatic apply_reset();
      ARSTn = 1'b0;
      repeat (4) step();
      check_status(status, ecode, qeci_pkg::ST_RESET, qeci_pkg::EC_NONE);
      check_flag("tx_ready", tx_ready, 1'b0);
      check_flag("rx_valid", rx_valid, 1'b0);
      check_flag("link_tx_valid", link_tx_valid, 1'b0);
      ARSTn = 1'b1;
   endtask

   task automatic wait_link_up();
      while (status != qeci_pkg::ST_LINKUP) begin
         step();
      end
      check_status(status, ecode, qeci_pkg::ST_LINKUP, qeci_pkg::EC_NONE);
      check_flag("tx_ready", tx_ready, 1'b1);
   endtask

   initial begin
      int                    exp_idx;
      logic                  exp_on;
      qeci_pkg::qeci_frame_u exp_frame;
      FCLK     = 1'b0;
      ARSTn    = 1'b0;
      tx_data  = '0;
      tx_valid = 1'b0;
      flip     = '0;
      fill_table();
      apply_reset();
      wait_link_up();
      for (int i = 0; i < N_ROWS + 1; i++) begin
         if (i < N_ROWS) begin
            check_flag("tx_ready", tx_ready, 1'b1);
            tx_valid = rows[i].valid;
            tx_data  = rows[i].payload;
         end else begin
            tx_valid = 1'b0;
         end
         step();
         // Row i is now on the link and rx holds the row before it
         flip    = (i < N_ROWS) ? rows[i].flip : '0;
         exp_idx = i - 1;
         exp_on  = (exp_idx >= 0) ? rows[exp_idx].expect_rx : 1'b0;
         if (i < N_ROWS) begin
            exp_frame = '0;
            if (rows[i].valid) begin
               exp_frame.data.crc     = crc8_ref(rows[i].payload);
               exp_frame.data.payload = rows[i].payload;
            end else begin
               exp_frame.ctrl.kind = 1'b1;
               exp_frame.ctrl.code = qeci_pkg::CODE_IDLE;
            end
            check_frame(i, link_tx_frame, exp_frame);
         end
         check_flag("rx_valid", rx_valid, exp_on);
         if (exp_on) begin
            check_word($sformatf("rx_data of row %0d", exp_idx), rx_data,
                       rows[exp_idx].payload);
         end
      end
      check_status(status, ecode, qeci_pkg::ST_FAULT, qeci_pkg::EC_CRC);
      check_flag("tx_ready", tx_ready, 1'b0);
      check_flag("rx_valid", rx_valid, 1'b0);
      apply_reset();
      wait_link_up();
      $display("Simulation passed");
      $finish;
   end

endmodule
